/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - files:
      - rtl/eeprom_pkg.sv
      - rtl/eeprom_cmd_regs.sv
      - rtl/eeprom_seq.sv
      - rtl/eeprom_bit_engine.sv
      - rtl/eeprom_ctrl_top.sv
  - target: test
    files:
      - tests/eeprom_slave_model.sv
      - tests/eeprom_ctrl_sva.sv
      - tests/tb_eeprom_ctrl.sv

/* rtl/eeprom_bit_engine.sv */
`timescale 1ns/1ps

module eeprom_bit_engine import eeprom_pkg::*; #(
    parameter int SCL_HALF = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              op_go,
    input  bus_op_t           op,
    input  logic [DATA_W-1:0] tx_byte,
    output logic              op_done,
    output logic [DATA_W-1:0] rx_byte,
    output logic              ack_n,
    output logic              scl,
    output logic              sda_pull_low,
    input  logic              sda_in
);

    localparam int CNT_W = (SCL_HALF > 1) ? $clog2(SCL_HALF) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_HALF - 1);
    // sda moves one CLK after scl when the half period allows it
    localparam logic [CNT_W-1:0] SDA_AT = (SCL_HALF > 1) ? CNT_W'(1) : CNT_W'(0);
    localparam logic [4:0] LAST_BYTE = 5'd17;  // 9 bits, two halves each
    localparam logic [4:0] LAST_EDGE = 5'd2;   // start and stop use three halves

    logic              active;
    bus_op_t           op_q;
    logic [DATA_W-1:0] tx_q;
    logic [CNT_W-1:0]  cnt;
    logic [4:0]        hidx;   // half period index within the operation
    logic [3:0]        bit_idx;
    logic              byte_op;
    logic              half_end;
    logic              last_half;
    logic              want_scl;
    logic              want_low;

    assign bit_idx   = hidx[4:1];
    assign byte_op   = (op_q == OP_WRITE) || (op_q == OP_READ);
    assign half_end  = (cnt == CNT_LAST);
    assign last_half = byte_op ? (hidx == LAST_BYTE) : (hidx == LAST_EDGE);

    // bus levels wanted in the current half
    always_comb begin
        want_scl = 1'b1;
        want_low = 1'b0;
        case (op_q)
            OP_START: begin
                want_scl = (hidx != 5'd0);  // low first so a slave lets go of sda
                want_low = (hidx == 5'd2);
            end
            OP_STOP: begin
                want_scl = (hidx != 5'd0);
                want_low = (hidx != 5'd2);
            end
            OP_WRITE: begin
                want_scl = hidx[0];
                if (bit_idx < 4'd8) begin
                    want_low = ~tx_q[3'(DATA_W - 1) - bit_idx[2:0]];  // msb first
                end
            end
            default: want_scl = hidx[0];  // read and nack leave sda released
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active       <= 1'b0;
            op_done      <= 1'b0;
            scl          <= 1'b1;
            sda_pull_low <= 1'b0;
            cnt          <= '0;
            hidx         <= '0;
        end else begin
            op_done <= 1'b0;
            if (!active) begin
                if (op_go) begin
                    active <= 1'b1;
                    cnt    <= '0;
                    hidx   <= '0;
                end
            end else begin
                if (cnt == '0) begin
                    scl <= want_scl;
                end
                if (cnt == SDA_AT) begin
                    sda_pull_low <= want_low;
                end
                if (half_end) begin
                    cnt <= '0;
                    if (last_half) begin
                        active  <= 1'b0;
                        op_done <= 1'b1;
                    end else begin
                        hidx <= hidx + 5'd1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // operation latch and samples at the end of scl high
    always_ff @(posedge CLK) begin
        if (op_go && !active) begin
            op_q <= op;
            tx_q <= tx_byte;
        end
        if (active && half_end && hidx[0]) begin
            if (op_q == OP_READ && bit_idx < 4'd8) begin
                rx_byte <= {rx_byte[DATA_W-2:0], sda_in};
            end
            if (op_q == OP_WRITE && bit_idx == 4'd8) begin
                ack_n <= sda_in;  // 0 means the slave acked
            end
        end
    end

endmodule

/* rtl/eeprom_cmd_regs.sv */
`timescale 1ns/1ps

module eeprom_cmd_regs import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic              busy,
    output logic              done,
    output logic [DATA_W-1:0] rdata,
    output logic              ack_error,
    output logic              cmd_go,
    output logic              cmd_read,
    output logic [ADDR_W-1:0] cmd_addr,
    output logic [DATA_W-1:0] cmd_wdata,
    input  logic              seq_done,
    input  logic [DATA_W-1:0] seq_rdata,
    input  logic              seq_ack_err
);

    logic accept;

    assign accept = (wr | rd) & ~busy;  // strobes while busy are dropped

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd_go    <= 1'b0;
            rdata     <= '0;
            ack_error <= 1'b0;
        end else begin
            cmd_go <= accept;
            done   <= seq_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (seq_done) begin
                busy <= 1'b0;
            end
            // result holds until the next transaction ends
            if (seq_done) begin
                rdata     <= seq_rdata;
                ack_error <= seq_ack_err;
            end
        end
    end

    // command fields stay put for the whole transaction
    always_ff @(posedge CLK) begin
        if (accept) begin
            cmd_read  <= ~wr;  // wr wins over rd
            cmd_addr  <= addr;
            cmd_wdata <= wdata;
        end
    end

endmodule

/* rtl/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top import eeprom_pkg::*; #(
    parameter int SCL_HALF = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic              busy,
    output logic              done,
    output logic [DATA_W-1:0] rdata,
    output logic              ack_error,
    output logic              scl,
    inout  wire               sda
);

    // host command to sequencer
    logic              cmd_go;
    logic              cmd_read;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              seq_done;
    logic [DATA_W-1:0] seq_rdata;
    logic              seq_ack_err;

    // sequencer to bit engine
    logic              op_go;
    bus_op_t           op;
    logic [DATA_W-1:0] tx_byte;
    logic              op_done;
    logic [DATA_W-1:0] rx_byte;
    logic              ack_n;

    logic              sda_pull_low;
    wire               sda_in;

    assign sda    = sda_pull_low ? 1'b0 : 1'bz;  // open drain, pull-up is external
    assign sda_in = sda;

    eeprom_cmd_regs u_cmd_regs (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .done        (done),
        .rdata       (rdata),
        .ack_error   (ack_error),
        .cmd_go      (cmd_go),
        .cmd_read    (cmd_read),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .seq_done    (seq_done),
        .seq_rdata   (seq_rdata),
        .seq_ack_err (seq_ack_err)
    );

    eeprom_seq u_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_go      (cmd_go),
        .cmd_read    (cmd_read),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .seq_done    (seq_done),
        .seq_rdata   (seq_rdata),
        .seq_ack_err (seq_ack_err),
        .op_go       (op_go),
        .op          (op),
        .tx_byte     (tx_byte),
        .op_done     (op_done),
        .rx_byte     (rx_byte),
        .ack_n       (ack_n)
    );

    eeprom_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) u_bit_engine (
        .CLK          (CLK),
        .RESET        (RESET),
        .op_go        (op_go),
        .op           (op),
        .tx_byte      (tx_byte),
        .op_done      (op_done),
        .rx_byte      (rx_byte),
        .ack_n        (ack_n),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

endmodule

/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // operations the sequencer hands to the bit engine
    typedef enum logic [1:0] {
        OP_START = 2'd0,  // start, also used as repeated start
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,  // send byte, sample ack
        OP_READ  = 2'd3   // receive byte, send nack
    } bus_op_t;

    // device type code in the top nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // 2 Kbyte part: 8 bits in the address byte, 3 in the control byte
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

endpackage

/* rtl/eeprom_seq.sv */
`timescale 1ns/1ps

module eeprom_seq import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_go,
    input  logic              cmd_read,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    output logic              seq_done,
    output logic [DATA_W-1:0] seq_rdata,
    output logic              seq_ack_err,
    output logic              op_go,
    output bus_op_t           op,
    output logic [DATA_W-1:0] tx_byte,
    input  logic              op_done,
    input  logic [DATA_W-1:0] rx_byte,
    input  logic              ack_n
);

    // one-hot state bits
    localparam int S_IDLE   = 0;
    localparam int S_START  = 1;
    localparam int S_CTRL_W = 2;
    localparam int S_ADDR   = 3;
    localparam int S_DATA   = 4;
    localparam int S_RSTART = 5;
    localparam int S_CTRL_R = 6;
    localparam int S_READ   = 7;
    localparam int S_STOP   = 8;
    localparam int NS       = 9;

    logic [NS-1:0]     state;
    logic [NS-1:0]     nxt_state;
    logic              issue;
    bus_op_t           nxt_op;
    logic [DATA_W-1:0] nxt_byte;
    logic [DATA_W-1:0] ctrl_wr;
    logic [DATA_W-1:0] ctrl_rd;
    logic              wrote;

    function automatic logic [NS-1:0] st(input int idx);
        logic [NS-1:0] v;
        v      = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    // device code, A10..A8, r/w
    assign ctrl_wr = {DEV_CODE, cmd_addr[ADDR_W-1:DATA_W], 1'b0};
    assign ctrl_rd = {DEV_CODE, cmd_addr[ADDR_W-1:DATA_W], 1'b1};

    // states whose operation is a byte write with ack
    assign wrote = state[S_CTRL_W] | state[S_ADDR] | state[S_DATA] | state[S_CTRL_R];

    always_comb begin
        nxt_state = state;
        issue     = 1'b0;
        nxt_op    = OP_START;
        nxt_byte  = '0;
        case (1'b1)
            state[S_IDLE]: if (cmd_go) begin
                nxt_state = st(S_START);
                issue     = 1'b1;
            end
            state[S_START]: if (op_done) begin
                nxt_state = st(S_CTRL_W);
                issue     = 1'b1;
                nxt_op    = OP_WRITE;
                nxt_byte  = ctrl_wr;
            end
            state[S_CTRL_W]: if (op_done) begin
                nxt_state = st(S_ADDR);
                issue     = 1'b1;
                nxt_op    = OP_WRITE;
                nxt_byte  = cmd_addr[DATA_W-1:0];
            end
            state[S_ADDR]: if (op_done) begin
                issue = 1'b1;
                if (cmd_read) begin
                    nxt_state = st(S_RSTART);  // dummy write done, turn around
                end else begin
                    nxt_state = st(S_DATA);
                    nxt_op    = OP_WRITE;
                    nxt_byte  = cmd_wdata;
                end
            end
            state[S_RSTART]: if (op_done) begin
                nxt_state = st(S_CTRL_R);
                issue     = 1'b1;
                nxt_op    = OP_WRITE;
                nxt_byte  = ctrl_rd;
            end
            state[S_CTRL_R]: if (op_done) begin
                nxt_state = st(S_READ);
                issue     = 1'b1;
                nxt_op    = OP_READ;
            end
            state[S_DATA], state[S_READ]: if (op_done) begin
                nxt_state = st(S_STOP);
                issue     = 1'b1;
                nxt_op    = OP_STOP;
            end
            state[S_STOP]: if (op_done) begin
                nxt_state = st(S_IDLE);
            end
            default: nxt_state = st(S_IDLE);
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state       <= st(S_IDLE);
            op_go       <= 1'b0;
            seq_done    <= 1'b0;
            seq_ack_err <= 1'b0;
        end else begin
            state    <= nxt_state;
            op_go    <= issue;
            seq_done <= state[S_STOP] & op_done;
            if (state[S_IDLE] & cmd_go) begin
                seq_ack_err <= 1'b0;
            end else if (wrote & op_done) begin
                seq_ack_err <= seq_ack_err | ack_n;  // keep going, just note it
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            op      <= nxt_op;
            tx_byte <= nxt_byte;
        end
        if (state[S_IDLE] & cmd_go) begin
            seq_rdata <= '0;
        end else if (state[S_READ] & op_done) begin
            seq_rdata <= rx_byte;
        end
    end

endmodule

/* tb.f */
rtl/eeprom_pkg.sv
rtl/eeprom_cmd_regs.sv
rtl/eeprom_seq.sv
rtl/eeprom_bit_engine.sv
rtl/eeprom_ctrl_top.sv
tests/eeprom_slave_model.sv
tests/eeprom_ctrl_sva.sv
tests/tb_eeprom_ctrl.sv

/* tests/eeprom_ctrl_sva.sv */
`timescale 1ns/1ps

module eeprom_ctrl_sva (
    input logic CLK,
    input logic RESET,
    input logic wr,
    input logic rd,
    input logic busy,
    input logic done,
    input logic scl,
    input logic sda_pull_low
);

    int fail_count = 0;

    // one-cycle done, busy already dropped
    done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |-> !busy ##1 !done)
        else begin
            $error("done not a single cycle with busy low");
            fail_count++;
        end

    busy_cause: assert property (@(posedge CLK) disable iff (RESET) $rose(busy) |-> $past(wr || rd))
        else begin
            $error("busy rose without a host strobe");
            fail_count++;
        end

    // idle bus between transactions
    bus_idle: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl && !sda_pull_low)
        else begin
            $error("bus not idle while not busy");
            fail_count++;
        end

endmodule

/* tests/eeprom_slave_model.sv */
`timescale 1ns/1ps

module eeprom_slave_model import eeprom_pkg::*; (
    input  logic scl,
    inout  wire  sda,
    input  logic ack_enable  // low: part acks nothing
);

    localparam int ST_IDLE = 0;
    localparam int ST_CTRL = 1;
    localparam int ST_ADDR = 2;
    localparam int ST_DATA = 3;
    localparam int ST_SEND = 4;

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];
    logic [ADDR_W-1:0] ptr;
    logic [2:0]        addr_hi;
    logic [DATA_W-1:0] shift;
    int                cnt;
    int                state;
    int                nxt_state;
    logic              drive_low;
    logic              scl_q;
    logic              sda_q;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = '1;  // erased part
        end
        ptr       = '0;
        addr_hi   = '0;
        shift     = '0;
        cnt       = 0;
        state     = ST_IDLE;
        nxt_state = ST_IDLE;
        drive_low = 1'b0;
    end

    // called on the scl fall that opens the ack slot
    task automatic take_byte();
        if (!ack_enable || (state == ST_CTRL && shift[7:4] != DEV_CODE)) begin
            state = ST_IDLE;  // no ack, wait for the next start
        end else begin
            drive_low = 1'b1;
            case (state)
                ST_CTRL: begin
                    addr_hi   = shift[3:1];
                    nxt_state = shift[0] ? ST_SEND : ST_ADDR;
                end
                ST_ADDR: begin
                    ptr       = {addr_hi, shift};
                    nxt_state = ST_DATA;
                end
                default: begin
                    mem[ptr]  = shift;
                    nxt_state = ST_IDLE;  // single byte writes only
                end
            endcase
        end
    endtask

    always @(scl or sda) begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            state     = ST_CTRL;  // start or repeated start
            cnt       = 0;
            drive_low = 1'b0;
        end else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            state     = ST_IDLE;  // stop
            drive_low = 1'b0;
        end else if (state != ST_IDLE && scl_q === 1'b0 && scl === 1'b1) begin
            if (cnt < 8 && state != ST_SEND) begin
                shift = {shift[DATA_W-2:0], sda};
            end
            cnt = cnt + 1;
            if (cnt == 9 && state == ST_SEND) begin
                state = ST_IDLE;  // master nack ends the read
            end
        end else if (state != ST_IDLE && scl_q === 1'b1 && scl === 1'b0) begin
            if (state == ST_SEND) begin
                drive_low = (cnt < 8) ? ~shift[DATA_W-1-cnt] : 1'b0;
            end else if (cnt == 8) begin
                take_byte();
            end else if (cnt == 9) begin
                drive_low = 1'b0;
                cnt       = 0;
                state     = nxt_state;
                if (state == ST_SEND) begin
                    shift     = mem[ptr];
                    drive_low = ~shift[DATA_W-1];
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tests/tb_eeprom_ctrl.sv */
`timescale 1ns/1ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int N_RANDOM   = 150;
    localparam int MAX_CYCLES = 100000;  // ~200 transactions, 60 bit times of 4 cycles

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              busy;
    logic              done;
    logic [DATA_W-1:0] rdata;
    logic              ack_error;
    logic              scl;
    wire               sda;
    logic              ack_enable;

    logic [DATA_W-1:0] ref_mem [0:(1 << ADDR_W) - 1];
    logic [ADDR_W-1:0] written [$];
    integer            seed;
    int                cmd_count;
    int                done_count;
    int                cycles;

    pullup (sda);

    eeprom_ctrl_top #(
        .SCL_HALF (2)
    ) UUT (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ack_error (ack_error),
        .scl       (scl),
        .sda       (sda)
    );

    eeprom_slave_model u_eeprom (
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable)
    );

    bind eeprom_ctrl_top eeprom_ctrl_sva u_sva (
        .CLK  (CLK),
        .RESET (RESET),
        .wr   (wr),
        .rd   (rd),
        .busy (busy),
        .done (done),
        .scl  (scl),
        .sda_pull_low (sda_pull_low)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge done) done_count = done_count + 1;

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (UUT.u_sva.fail_count != 0) begin
            $display("assertion failure in the bus checker");
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure");
        end else if (cycles >= MAX_CYCLES) begin
            $display("timeout: transactions did not finish");
            $display("FAIL: see errors above");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic send_cmd(input logic is_rd, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d);
        @(negedge CLK);
        wr    = ~is_rd;
        rd    = is_rd;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr        = 1'b0;
        rd        = 1'b0;
        cmd_count = cmd_count + 1;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(negedge CLK);
        end
    endtask

    // ack expected only while the slave answers
    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        send_cmd(1'b0, a, d);
        wait_done();
        check(ack_error, !ack_enable, "write ack_error");
        if (ack_enable) begin
            ref_mem[a] = d;
            written.push_back(a);
        end
    endtask

    task automatic read_and_compare(input logic [ADDR_W-1:0] a);
        send_cmd(1'b1, a, '0);
        wait_done();
        check(ack_error, 1'b0, "read ack_error");
        check(rdata, ref_mem[a], $sformatf("read data at %03h", a));
    endtask

    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] old;

        seed       = 14;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        ack_enable = 1'b1;
        cmd_count  = 0;
        done_count = 0;
        cycles     = 0;
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            ref_mem[i] = '1;
        end
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        @(negedge CLK);
        check(busy, 1'b0, "busy after reset");
        check(done, 1'b0, "done after reset");
        check(ack_error, 1'b0, "ack_error after reset");
        check(rdata, 8'h00, "rdata after reset");
        check(scl, 1'b1, "scl after reset");

        read_and_compare(11'h000);
        check(rdata, 8'hFF, "unwritten byte");
        write_byte(11'h5A3, 8'h3C);
        read_and_compare(11'h5A3);
        check(rdata, 8'h3C, "read back");

        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            if (r[0]) begin
                a = r[ADDR_W:1];
                r = $random(seed);
                write_byte(a, r[DATA_W-1:0]);
            end else if (r[1] && written.size() > 0) begin
                r = $random(seed);
                read_and_compare(written[r % written.size()]);  // revisit a written byte
            end else begin
                read_and_compare(r[ADDR_W+1:2]);
            end
        end

        // extra strobes land while the first write is in flight
        send_cmd(1'b0, 11'h2D1, 8'hA5);
        repeat (3) begin
            @(negedge CLK);
            check(busy, 1'b1, "busy during extra strobes");
            wr    = 1'b1;
            addr  = 11'h2D1;
            wdata = 8'h5A;
            @(negedge CLK);
            wr = 1'b0;
        end
        wait_done();
        check(ack_error, 1'b0, "first write ack_error");
        ref_mem[11'h2D1] = 8'hA5;
        read_and_compare(11'h2D1);
        check(done_count, cmd_count, "done pulses vs accepted commands");

        a          = 11'h5A3;
        old        = ref_mem[a];
        ack_enable = 1'b0;
        write_byte(a, ~old);
        ack_enable = 1'b1;
        read_and_compare(a);
        check(rdata, old, "byte kept after missing ack");
        check(done_count, cmd_count, "done pulses vs accepted commands");

        if (UUT.u_sva.fail_count != 0) begin
            $display("%0d assertion failures in the bus checker", UUT.u_sva.fail_count);
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
